// File: hdl/cpu_pkg.sv
// Shared widths, register codes, flag indices and enums, imported by every core unit
package cpu_pkg;

    // Data and address widths
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [19:0] addr_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [4:0]  flags_t;

    // Register codes; with byte size, 4..7 select AH, CH, DH, BH
    localparam reg_sel_t REG_AX = 3'd0;
    localparam reg_sel_t REG_CX = 3'd1;
    localparam reg_sel_t REG_DX = 3'd2;
    localparam reg_sel_t REG_BX = 3'd3;
    localparam reg_sel_t REG_SP = 3'd4;
    localparam reg_sel_t REG_BP = 3'd5;
    localparam reg_sel_t REG_SI = 3'd6;
    localparam reg_sel_t REG_DI = 3'd7;

    // Bit positions inside flags_t
    localparam int FLAG_C = 0;
    localparam int FLAG_P = 1;
    localparam int FLAG_Z = 2;
    localparam int FLAG_S = 3;
    localparam int FLAG_O = 4;

    // Values follow opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD, ALU_OR, ALU_ADC, ALU_SBB, ALU_AND, ALU_SUB, ALU_XOR, ALU_CMP
    } alu_op_t;

    typedef enum logic [2:0] {
        FLAGS_HOLD, FLAGS_ALL, FLAGS_KEEP_C, FLAGS_SET_C, FLAGS_CLR_C, FLAGS_CMC
    } flag_mode_t;

    typedef enum logic [2:0] {
        FETCH, IMM, EXEC, WRITE_REG, PUSH_LO, PUSH_HI, POP_LO, POP_HI
    } seq_state_t;

    typedef enum logic {
        ADDR_IP, ADDR_STACK
    } addr_src_t;

endpackage

// File: hdl/reg_port_if.sv
// Register file port, driven by the sequencer and served by the register file
`timescale 1ns/1ns

interface reg_port_if import cpu_pkg::*; ();
    // Combinational read
    reg_sel_t rd_sel;
    logic     rd_size;
    word_t    rd_data;
    // Write at the next enabled edge
    logic     wr_en;
    reg_sel_t wr_sel;
    logic     wr_size;
    word_t    wr_data;
    // Stack pointer strobes, never both at once
    logic     sp_dec2;
    logic     sp_inc2;
    word_t    sp;

    modport sequencer (
        output rd_sel, rd_size, wr_en, wr_sel, wr_size, wr_data, sp_dec2, sp_inc2,
        input  rd_data
    );

    modport register_file (
        input  rd_sel, rd_size, wr_en, wr_sel, wr_size, wr_data, sp_dec2, sp_inc2,
        output rd_data, sp
    );
endinterface

// File: hdl/alu_if.sv
// ALU port between the sequencer and the ALU unit, with flag update and branch test
`timescale 1ns/1ns

interface alu_if import cpu_pkg::*; ();
    alu_op_t    op;
    logic       size;
    word_t      a;
    word_t      b;
    flag_mode_t flag_mode;
    // Jcc condition, opcode bits 3:1 and bit 0
    logic [2:0] cond_sel;
    logic       cond_neg;
    word_t      result;
    logic       cond_true;

    modport sequencer (
        output op, size, a, b, flag_mode, cond_sel, cond_neg,
        input  result, cond_true
    );

    modport alu (
        input  op, size, a, b, flag_mode, cond_sel, cond_neg,
        output result, cond_true
    );
endinterface

// File: hdl/register_file.sv
// General register file AX..DI with byte and word access and stack pointer stepping
`timescale 1ns/1ns

module register_file import cpu_pkg::*; #(
    parameter word_t RESET_SP = 16'hFFF0
) (
    input logic         clock,
    input logic         ce,
    input logic         reset_n,
    reg_port_if.register_file port
);

    word_t gpr [8];

    // Byte codes 4..7 map onto the high half of AX..BX
    always_comb begin
        if (port.rd_size) begin
            port.rd_data = gpr[port.rd_sel];
        end else if (port.rd_sel[2]) begin
            port.rd_data = {8'h00, gpr[{1'b0, port.rd_sel[1:0]}][15:8]};
        end else begin
            port.rd_data = {8'h00, gpr[port.rd_sel][7:0]};
        end
    end

    assign port.sp = gpr[REG_SP];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) begin
                gpr[i] <= '0;
            end
            gpr[REG_SP] <= RESET_SP;
        end else if (ce) begin
            if (port.sp_dec2) begin
                gpr[REG_SP] <= gpr[REG_SP] - 16'd2;
            end else if (port.sp_inc2) begin
                gpr[REG_SP] <= gpr[REG_SP] + 16'd2;
            end
            // A register write wins over the SP step
            if (port.wr_en) begin
                if (port.wr_size) begin
                    gpr[port.wr_sel] <= port.wr_data;
                end else if (port.wr_sel[2]) begin
                    gpr[{1'b0, port.wr_sel[1:0]}][15:8] <= port.wr_data[7:0];
                end else begin
                    gpr[port.wr_sel][7:0] <= port.wr_data[7:0];
                end
            end
        end
    end

endmodule

// File: hdl/alu_unit.sv
// Accumulator ALU with flag register and Jcc condition evaluation
`timescale 1ns/1ns

module alu_unit import cpu_pkg::*; (
    input logic clock,
    input logic ce,
    input logic reset_n,
    alu_if.alu  alu
);

    flags_t      flags;
    flags_t      new_flags;
    logic [16:0] a_ext;
    logic [16:0] b_ext;
    logic [16:0] sum;
    logic        is_sub;
    logic        is_logic;
    logic        msb_a;
    logic        msb_b;
    logic        msb_r;
    logic        cond;

    // ------------------------------------------------------------------
    // Arithmetic and flag derivation
    // ------------------------------------------------------------------
    always_comb begin
        a_ext    = alu.size ? {1'b0, alu.a} : {9'd0, alu.a[7:0]};
        b_ext    = alu.size ? {1'b0, alu.b} : {9'd0, alu.b[7:0]};
        sum      = a_ext + b_ext;
        is_sub   = 1'b0;
        is_logic = 1'b0;
        case (alu.op)
            ALU_ADC: sum = a_ext + b_ext + {16'd0, flags[FLAG_C]};
            ALU_SBB: begin
                sum    = a_ext - b_ext - {16'd0, flags[FLAG_C]};
                is_sub = 1'b1;
            end
            ALU_SUB, ALU_CMP: begin
                sum    = a_ext - b_ext;
                is_sub = 1'b1;
            end
            ALU_OR: begin
                sum      = a_ext | b_ext;
                is_logic = 1'b1;
            end
            ALU_AND: begin
                sum      = a_ext & b_ext;
                is_logic = 1'b1;
            end
            ALU_XOR: begin
                sum      = a_ext ^ b_ext;
                is_logic = 1'b1;
            end
            default: ;
        endcase

        msb_a = alu.size ? alu.a[15] : alu.a[7];
        msb_b = alu.size ? alu.b[15] : alu.b[7];
        msb_r = alu.size ? sum[15] : sum[7];

        // Carry or borrow lands just above the operand width
        new_flags[FLAG_C] = !is_logic && (alu.size ? sum[16] : sum[8]);
        new_flags[FLAG_P] = ~^sum[7:0];
        new_flags[FLAG_Z] = alu.size ? (sum[15:0] == 16'd0) : (sum[7:0] == 8'd0);
        new_flags[FLAG_S] = msb_r;
        new_flags[FLAG_O] = !is_logic && (msb_r != msb_a) &&
                            (is_sub ? (msb_a != msb_b) : (msb_a == msb_b));
    end

    assign alu.result = sum[15:0];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            flags <= '0;
        end else if (ce) begin
            case (alu.flag_mode)
                FLAGS_ALL: flags <= new_flags;
                FLAGS_KEEP_C: begin
                    flags         <= new_flags;
                    flags[FLAG_C] <= flags[FLAG_C];
                end
                FLAGS_SET_C: flags[FLAG_C] <= 1'b1;
                FLAGS_CLR_C: flags[FLAG_C] <= 1'b0;
                FLAGS_CMC:   flags[FLAG_C] <= ~flags[FLAG_C];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Branch conditions, in 8086 Jcc order
    // ------------------------------------------------------------------
    always_comb begin
        case (alu.cond_sel)
            3'd0: cond = flags[FLAG_O];
            3'd1: cond = flags[FLAG_C];
            3'd2: cond = flags[FLAG_Z];
            3'd3: cond = flags[FLAG_C] | flags[FLAG_Z];
            3'd4: cond = flags[FLAG_S];
            3'd5: cond = flags[FLAG_P];
            3'd6: cond = flags[FLAG_S] ^ flags[FLAG_O];
            default: cond = (flags[FLAG_S] ^ flags[FLAG_O]) | flags[FLAG_Z];
        endcase
    end

    assign alu.cond_true = cond ^ alu.cond_neg;

endmodule

// File: hdl/step_counter.sv
// Counts the immediate bytes still to read and reports the current byte index
`timescale 1ns/1ns

module step_counter (
    input  logic       clock,
    input  logic       ce,
    input  logic       reset_n,
    input  logic       load,
    input  logic       step,
    input  logic [1:0] count,
    output logic       last,
    output logic       index
);

    logic [1:0] remaining;
    logic       byte_idx;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            remaining <= 2'd0;
            byte_idx  <= 1'b0;
        end else if (ce) begin
            if (load) begin
                remaining <= count;
                byte_idx  <= 1'b0;
            end else if (step && remaining != 2'd0) begin
                remaining <= remaining - 2'd1;
                byte_idx  <= 1'b1;
            end
        end
    end

    // Low byte first, high byte second
    assign last  = (remaining == 2'd1);
    assign index = byte_idx;

endmodule

// File: hdl/address_unit.sv
// Instruction pointer, stack address latch and bus address selection
`timescale 1ns/1ns

module address_unit import cpu_pkg::*; (
    input  logic      clock,
    input  logic      ce,
    input  logic      reset_n,
    input  logic      ip_inc,
    input  logic      ip_rel,
    input  logic      stack_load,
    input  logic      stack_next,
    input  byte_t     disp,
    input  word_t     sp,
    input  addr_src_t addr_src,
    output addr_t     mem_addr
);

    word_t ip;
    word_t stack_addr;
    word_t stack_cur;
    word_t rel;

    // Low byte phase takes SP directly, the high byte uses the latch
    assign stack_cur = stack_load ? sp : stack_addr;
    assign rel       = ip_rel ? {{8{disp[7]}}, disp} : 16'd0;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ip <= '0;
        end else if (ce) begin
            // Displacement counts from the byte after it
            ip <= ip + {15'd0, ip_inc} + rel;
        end
    end

    always_ff @(posedge clock) begin
        if (ce && (stack_load || stack_next)) begin
            stack_addr <= stack_cur + 16'd1;
        end
    end

    // Flat 20-bit bus, top nibble always zero
    assign mem_addr = {4'h0, (addr_src == ADDR_STACK) ? stack_cur : ip};

endmodule

// File: hdl/sequencer.sv
// Opcode decoder and state machine that steers registers, ALU, counter and bus
`timescale 1ns/1ns

module sequencer import cpu_pkg::*; (
    input  logic       clock,
    input  logic       ce,
    input  logic       reset_n,
    input  byte_t      mem_rdata,
    input  logic       last,
    input  logic       index,
    reg_port_if.sequencer regs,
    alu_if.sequencer   alu,
    output logic       load,
    output logic       step,
    output logic [1:0] count,
    output logic       ip_inc,
    output logic       ip_rel,
    output logic       stack_load,
    output logic       stack_next,
    output logic       mem_we,
    output byte_t      disp,
    output byte_t      wdata,
    output addr_src_t  addr_src
);

    seq_state_t state;
    seq_state_t state_next;
    byte_t      opcode;
    word_t      latch;
    logic       we_req;

    always_comb begin
        state_next     = state;
        load           = 1'b0;
        step           = 1'b0;
        count          = 2'd1;
        ip_inc         = 1'b0;
        ip_rel         = 1'b0;
        stack_load     = 1'b0;
        stack_next     = 1'b0;
        we_req         = 1'b0;
        disp           = mem_rdata;
        wdata          = regs.rd_data[7:0];
        addr_src       = ADDR_IP;
        regs.rd_sel    = opcode[2:0];
        regs.rd_size   = 1'b1;
        regs.wr_en     = 1'b0;
        regs.wr_sel    = opcode[2:0];
        regs.wr_size   = 1'b1;
        regs.wr_data   = alu.result;
        regs.sp_dec2   = 1'b0;
        regs.sp_inc2   = 1'b0;
        alu.op         = alu_op_t'(opcode[5:3]);
        alu.size       = opcode[0];
        alu.a          = regs.rd_data;
        alu.b          = latch;
        alu.flag_mode  = FLAGS_HOLD;
        alu.cond_sel   = opcode[3:1];
        alu.cond_neg   = opcode[0];

        case (state)
            // ----------------------------------------------------------
            // Decode the opcode on the bus
            // ----------------------------------------------------------
            FETCH: begin
                ip_inc = 1'b1;
                casez (mem_rdata)
                    // MOV r,imm: bit 3 picks word size
                    8'b1011_????: begin
                        load       = 1'b1;
                        count      = mem_rdata[3] ? 2'd2 : 2'd1;
                        state_next = IMM;
                    end
                    // ALU acc,imm
                    8'b00??_?10?: begin
                        load       = 1'b1;
                        count      = mem_rdata[0] ? 2'd2 : 2'd1;
                        state_next = IMM;
                    end
                    8'b0100_????: state_next = WRITE_REG;
                    8'b0101_0???: begin
                        regs.sp_dec2 = 1'b1;
                        state_next   = PUSH_LO;
                    end
                    8'b0101_1???: state_next = POP_LO;
                    8'b0111_????, 8'hEB: state_next = EXEC;
                    // HLT stays on its own byte
                    8'hF4: ip_inc = 1'b0;
                    8'hF5: alu.flag_mode = FLAGS_CMC;
                    8'hF8: alu.flag_mode = FLAGS_CLR_C;
                    8'hF9: alu.flag_mode = FLAGS_SET_C;
                    default: ;
                endcase
            end

            IMM: begin
                ip_inc = 1'b1;
                step   = 1'b1;
                if (last) begin
                    state_next = EXEC;
                    // MOV writes straight from the bus
                    if (opcode[7:4] == 4'hB) begin
                        regs.wr_en   = 1'b1;
                        regs.wr_size = opcode[3];
                        regs.wr_data = index ? {mem_rdata, latch[7:0]} : {8'h00, mem_rdata};
                        state_next   = FETCH;
                    end
                end
            end

            EXEC: begin
                state_next = FETCH;
                if (opcode[7:6] == 2'b00) begin
                    regs.rd_sel   = REG_AX;
                    regs.rd_size  = opcode[0];
                    regs.wr_en    = (alu_op_t'(opcode[5:3]) != ALU_CMP);
                    regs.wr_sel   = REG_AX;
                    regs.wr_size  = opcode[0];
                    alu.flag_mode = FLAGS_ALL;
                end else begin
                    // Jcc or JMP short, displacement on the bus
                    ip_inc = 1'b1;
                    ip_rel = (opcode == 8'hEB) || alu.cond_true;
                end
            end

            // INC/DEC r16
            WRITE_REG: begin
                alu.op        = opcode[3] ? ALU_SUB : ALU_ADD;
                alu.size      = 1'b1;
                alu.b         = 16'd1;
                alu.flag_mode = FLAGS_KEEP_C;
                regs.wr_en    = 1'b1;
                state_next    = FETCH;
            end

            PUSH_LO: begin
                addr_src   = ADDR_STACK;
                stack_load = 1'b1;
                stack_next = 1'b1;
                we_req     = 1'b1;
                state_next = PUSH_HI;
            end

            PUSH_HI: begin
                addr_src   = ADDR_STACK;
                we_req     = 1'b1;
                wdata      = regs.rd_data[15:8];
                state_next = FETCH;
            end

            POP_LO: begin
                addr_src     = ADDR_STACK;
                stack_load   = 1'b1;
                stack_next   = 1'b1;
                regs.sp_inc2 = 1'b1;
                state_next   = POP_HI;
            end

            default: begin
                // POP_HI: low byte waits in the latch
                addr_src     = ADDR_STACK;
                regs.wr_en   = 1'b1;
                regs.wr_data = {mem_rdata, latch[7:0]};
                state_next   = FETCH;
            end
        endcase
    end

    assign mem_we = we_req & ce;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= FETCH;
        end else if (ce) begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (ce) begin
            if (state == FETCH) begin
                opcode <= mem_rdata;
            end
            if (state == IMM && index) begin
                latch[15:8] <= mem_rdata;
            end
            if ((state == IMM && !index) || state == POP_LO) begin
                latch[7:0] <= mem_rdata;
            end
        end
    end

endmodule

// File: hdl/core.sv
// Top level of the 8088-style core, wiring the sequencer to its datapath units
`timescale 1ns/1ns

module core import cpu_pkg::*; #(
    parameter word_t RESET_SP = 16'hFFF0
) (
    input  logic  clock,
    input  logic  ce,
    input  logic  reset_n,
    input  byte_t mem_rdata,
    output addr_t mem_addr,
    output byte_t mem_wdata,
    output logic  mem_we
);

    logic       load;
    logic       step;
    logic [1:0] count;
    logic       last;
    logic       index;
    logic       ip_inc;
    logic       ip_rel;
    logic       stack_load;
    logic       stack_next;
    byte_t      disp;
    addr_src_t  addr_src;

    reg_port_if reg_bus ();
    alu_if      alu_bus ();

    sequencer seq0 (
        .clock, .ce, .reset_n, .mem_rdata, .last, .index,
        .regs(reg_bus.sequencer),
        .alu(alu_bus.sequencer),
        .load, .step, .count, .ip_inc, .ip_rel, .stack_load, .stack_next,
        .mem_we, .disp,
        .wdata(mem_wdata),
        .addr_src
    );

    register_file #(.RESET_SP(RESET_SP)) regs0 (
        .clock, .ce, .reset_n,
        .port(reg_bus.register_file)
    );

    alu_unit alu0 (
        .clock, .ce, .reset_n,
        .alu(alu_bus.alu)
    );

    step_counter cnt0 (
        .clock, .ce, .reset_n, .load, .step, .count, .last, .index
    );

    address_unit addr0 (
        .clock, .ce, .reset_n, .ip_inc, .ip_rel, .stack_load, .stack_next, .disp,
        .sp(reg_bus.sp),
        .addr_src, .mem_addr
    );

endmodule

// File: dv/mem_model.sv
// Byte memory for the testbench, combinational read and clocked write, loaded before reset
`timescale 1ns/1ns

module mem_model import cpu_pkg::*; (
    input  logic  clock,
    input  logic  we,
    input  addr_t addr,
    input  byte_t wdata,
    output byte_t rdata
);

    byte_t mem [65536];

    // Top nibble of the bus is always zero
    assign rdata = mem[addr[15:0]];

    // The core never samples read data in a write cycle
    always @(posedge clock) begin
        if (we) begin
            mem[addr[15:0]] = wdata;
        end
    end

    task automatic load_byte(input word_t a, input byte_t d);
        mem[a] = d;
    endtask

endmodule

// File: dv/core_tb.sv
// Testbench top for the core that builds a program, models its writes and checks the bus
`timescale 1ns/1ns

module core_tb import cpu_pkg::*; ();

    localparam word_t SP0 = 16'hFFF0;

    logic   clock;
    logic   ce;
    logic   reset_n;
    byte_t  mem_rdata;
    addr_t  mem_addr;
    byte_t  mem_wdata;
    logic   mem_we;
    integer seed;

    // Reference model state
    word_t  m_reg [8];
    logic   m_c;
    logic   m_p;
    logic   m_z;
    logic   m_s;
    logic   m_o;
    byte_t  m_stack [int];
    byte_t  prog [$];
    word_t  exp_addr [$];
    byte_t  exp_data [$];
    int     wr_idx;
    word_t  hlt_addr;

    core dut0 (
        .clock, .ce, .reset_n, .mem_rdata, .mem_addr, .mem_wdata, .mem_we
    );

    mem_model mem0 (
        .clock, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // ------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_hang(input string msg);
        $display("Timeout: %s", msg);
        stop_with_failure();
    endtask

    function automatic word_t rand_word();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // ------------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------------
    task automatic expect_write(input word_t a, input byte_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        m_stack[int'(a)] = d;
    endtask

    task automatic model_push(input reg_sel_t r);
        word_t v;
        v = m_reg[r];
        m_reg[REG_SP] = m_reg[REG_SP] - 16'd2;
        expect_write(m_reg[REG_SP], v[7:0]);
        expect_write(m_reg[REG_SP] + 16'd1, v[15:8]);
    endtask

    // Signed and unsigned range checks give OF and CF
    task automatic compute_alu(input logic [2:0] op, input logic size, input word_t a,
                               input word_t b, input logic keep_c, output word_t res);
        int   ua;
        int   ub;
        int   sa;
        int   sb;
        int   full;
        int   sfull;
        int   mask;
        int   half;
        int   cin;
        int   r;
        logic arith;
        mask  = size ? 32'hFFFF : 32'hFF;
        half  = (mask + 1) / 2;
        ua    = int'(a) & mask;
        ub    = int'(b) & mask;
        sa    = (ua >= half) ? ua - mask - 1 : ua;
        sb    = (ub >= half) ? ub - mask - 1 : ub;
        cin   = m_c ? 1 : 0;
        // OR, AND and XOR clear CF and OF
        arith = !(op == 3'd1 || op == 3'd4 || op == 3'd6);
        case (op)
            3'd0:    full = ua + ub;
            3'd1:    full = ua | ub;
            3'd2:    full = ua + ub + cin;
            3'd3:    full = ua - ub - cin;
            3'd4:    full = ua & ub;
            3'd6:    full = ua ^ ub;
            default: full = ua - ub;
        endcase
        case (op)
            3'd0:       sfull = sa + sb;
            3'd2:       sfull = sa + sb + cin;
            3'd3:       sfull = sa - sb - cin;
            3'd5, 3'd7: sfull = sa - sb;
            default:    sfull = 0;
        endcase
        r   = full & mask;
        res = r[15:0];
        m_z = (r == 0);
        m_s = size ? r[15] : r[7];
        m_p = ~^r[7:0];
        m_o = arith && (sfull >= half || sfull < -half);
        if (!keep_c) begin
            m_c = arith && (full > mask || full < 0);
        end
    endtask

    function automatic logic cond_model(input logic [3:0] cc);
        logic t;
        case (cc[3:1])
            3'd0: t = m_o;
            3'd1: t = m_c;
            3'd2: t = m_z;
            3'd3: t = m_c | m_z;
            3'd4: t = m_s;
            3'd5: t = m_p;
            3'd6: t = m_s ^ m_o;
            default: t = (m_s ^ m_o) | m_z;
        endcase
        return t ^ cc[0];
    endfunction

    // ------------------------------------------------------------------
    // Program emitters that also update the model
    // ------------------------------------------------------------------
    task automatic emit_byte(input byte_t b);
        prog.push_back(b);
    endtask

    task automatic emit_mov16(input reg_sel_t r, input word_t v);
        emit_byte({5'b10111, r});
        emit_byte(v[7:0]);
        emit_byte(v[15:8]);
        m_reg[r] = v;
    endtask

    task automatic emit_mov8(input reg_sel_t code, input byte_t v);
        emit_byte({5'b10110, code});
        emit_byte(v);
        if (code[2]) begin
            m_reg[{1'b0, code[1:0]}][15:8] = v;
        end else begin
            m_reg[code][7:0] = v;
        end
    endtask

    task automatic emit_push(input reg_sel_t r);
        emit_byte({5'b01010, r});
        model_push(r);
    endtask

    task automatic emit_pop(input reg_sel_t r);
        word_t sp;
        emit_byte({5'b01011, r});
        sp = m_reg[REG_SP];
        m_reg[r] = {m_stack[int'(sp + 16'd1)], m_stack[int'(sp)]};
        m_reg[REG_SP] = sp + 16'd2;
    endtask

    task automatic emit_flag_op(input byte_t b);
        emit_byte(b);
        case (b)
            8'hF5: m_c = ~m_c;
            8'hF8: m_c = 1'b0;
            default: m_c = 1'b1;
        endcase
    endtask

    task automatic emit_alu(input logic [2:0] op, input logic size, input word_t imm);
        word_t res;
        emit_byte({2'b00, op, 2'b10, size});
        emit_byte(imm[7:0]);
        if (size) begin
            emit_byte(imm[15:8]);
        end
        compute_alu(op, size, m_reg[REG_AX], imm, 1'b0, res);
        if (op != 3'd7) begin
            if (size) begin
                m_reg[REG_AX] = res;
            end else begin
                m_reg[REG_AX][7:0] = res[7:0];
            end
        end
    endtask

    task automatic emit_incdec(input reg_sel_t r, input logic dec);
        word_t res;
        emit_byte({4'b0100, dec, r});
        compute_alu(dec ? 3'd5 : 3'd0, 1'b1, m_reg[r], 16'd1, 1'b1, res);
        m_reg[r] = res;
    endtask

    // Taken branch skips the one-byte marker PUSH CX
    task automatic emit_jcc_marker(input logic [3:0] cc);
        emit_byte({4'b0111, cc});
        emit_byte(8'h01);
        emit_byte({5'b01010, REG_CX});
        if (!cond_model(cc)) begin
            model_push(REG_CX);
        end
    endtask

    task automatic build_program();
        word_t v;
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = 16'd0;
        end
        m_reg[REG_SP] = SP0;
        {m_c, m_p, m_z, m_s, m_o} = 5'd0;

        emit_mov16(REG_AX, rand_word());
        emit_push(REG_AX);
        v = rand_word();
        emit_mov8(3'd4, v[7:0]);
        emit_push(REG_AX);

        for (int op = 0; op < 8; op++) begin
            for (int sz = 0; sz < 2; sz++) begin
                v = rand_word();
                emit_mov16(REG_AX, rand_word());
                emit_flag_op(v[0] ? 8'hF9 : 8'hF8);
                emit_alu(3'(op), 1'(sz), rand_word());
                emit_push(REG_AX);
            end
        end

        emit_mov16(REG_CX, rand_word());
        for (int cc = 0; cc < 16; cc++) begin
            v = rand_word();
            if (cc % 3 == 0) begin
                emit_flag_op(v[1] ? 8'hF5 : (v[0] ? 8'hF9 : 8'hF8));
            end else begin
                emit_mov16(REG_AX, rand_word());
                emit_alu(v[2:0], v[3], rand_word());
            end
            emit_jcc_marker(4'(cc));
        end

        // JMP short always skips its marker
        emit_byte(8'hEB);
        emit_byte(8'h01);
        emit_byte({5'b01010, REG_CX});

        for (int i = 0; i < 4; i++) begin
            emit_mov16(REG_DX, rand_word());
            emit_push(REG_DX);
            emit_pop(REG_BX);
            emit_incdec(REG_BX, 1'(i));
            emit_push(REG_BX);
        end

        hlt_addr = 16'(prog.size());
        emit_byte(8'hF4);
    endtask

    // ------------------------------------------------------------------
    // Bus checks at the falling edge
    // ------------------------------------------------------------------
    task automatic check_bus();
        if (mem_we) begin
            assert (wr_idx < exp_addr.size())
                else report_error($sformatf("unexpected write at %h", mem_addr));
            assert (mem_addr == {4'h0, exp_addr[wr_idx]} && mem_wdata == exp_data[wr_idx])
                else report_error($sformatf("write %0d got %h=%h, expected %h=%h", wr_idx,
                    mem_addr, mem_wdata, exp_addr[wr_idx], exp_data[wr_idx]));
            wr_idx++;
        end
    endtask

    task automatic hold_ce(input int n);
        addr_t hold;
        ce <= 1'b0;
        @(negedge clock);
        check_bus();
        hold = mem_addr;
        repeat (n - 1) begin
            @(posedge clock);
            ce <= 1'b0;
            @(negedge clock);
            assert (mem_addr == hold && !mem_we)
                else report_error("bus moved while ce was low");
            check_bus();
        end
    endtask

    initial begin
        int   cyc;
        logic done;
        seed    = 32'h8333_faba;
        ce      = 1'b0;
        reset_n = 1'b0;
        wr_idx  = 0;
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            mem0.load_byte(16'(i), prog[i]);
        end

        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        repeat (5) begin
            @(negedge clock);
            assert (mem_addr == 20'd0 && !mem_we)
                else report_error("bus not idle at address 0 after reset");
        end

        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            if (cyc == 40) begin
                hold_ce(6);
            end else begin
                ce <= (rand_word() & 16'd3) != 16'd0;
            end
            @(negedge clock);
            check_bus();
            done = (wr_idx == exp_addr.size()) && (mem_addr == {4'h0, hlt_addr});
            cyc++;
            if (cyc > 20000) begin
                report_hang("the core never reached the final HLT");
            end
        end

        // HLT keeps the bus on its own byte
        repeat (50) begin
            @(posedge clock);
            ce <= (rand_word() & 16'd3) != 16'd0;
            @(negedge clock);
            check_bus();
            assert (mem_addr == {4'h0, hlt_addr})
                else report_error($sformatf("address %h left HLT", mem_addr));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: cpu_lite.f
hdl/cpu_pkg.sv
hdl/reg_port_if.sv
hdl/alu_if.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/step_counter.sv
hdl/address_unit.sv
hdl/sequencer.sv
hdl/core.sv
dv/mem_model.sv
dv/core_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = core_tb
FILELIST = cpu_lite.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
